// File: verilog.f
+incdir+src
src/lc3b_types.sv
src/stage_reg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/forwarding_unit.sv
src/mem_stage.sv
src/cpu_datapath.sv
verif/tb_mem_model.sv
verif/tb_cpu_datapath.sv

// File: verif/tb_cpu_datapath.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module tb_cpu_datapath import lc3b_types::*; ();

    localparam int       PROG_LEN       = 26;
    localparam int       TIMEOUT_CYCLES = 40 * PROG_LEN + 100;
    localparam int       NUM_STORES     = 8;
    localparam lc3b_word LOAD_ADDR      = 16'hFFC0;
    localparam lc3b_word LOAD_WORD      = 16'h1234;
    localparam lc3b_word SHADOW_ADDR    = 16'hFFF0;
    localparam lc3b_word FLAG_ADDR      = 16'hFFFE;

    logic       clk;
    logic       rst_n;
    logic       resp_a;
    lc3b_word   rdata_a;
    logic       read_a;
    logic       write_a;
    logic [1:0] wmask_a;
    lc3b_word   address_a;
    lc3b_word   wdata_a;
    logic       resp_b;
    lc3b_word   rdata_b;
    logic       read_b;
    logic       write_b;
    logic [1:0] wmask_b;
    lc3b_word   address_b;
    lc3b_word   wdata_b;

    lc3b_word   exp_addr [NUM_STORES];
    lc3b_word   exp_data [NUM_STORES];
    string      test_name [NUM_STORES];
    int         store_idx  = 0;
    int         exp_slot;
    int         cycles     = 0;
    logic       flag_seen  = 1'b0;
    logic       fetch_seen = 1'b0;

    cpu_datapath i_cpu_datapath (.*);

    tb_mem_model #(
        .LOAD_ADDR (LOAD_ADDR),
        .LOAD_WORD (LOAD_WORD)
    ) i_mem (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string test, input lc3b_word expected,
                                   input lc3b_word actual);
        fail_run($sformatf("CHECK FAILED %s expected %h actual %h", test, expected, actual));
    endtask

    task automatic set_store(input int idx, input string test, input lc3b_word addr,
                             input lc3b_word data);
        test_name[idx] = test;
        exp_addr[idx]  = addr;
        exp_data[idx]  = data;
    endtask

    // program order, r0 stays 0 so each address is 2 * offset6
    task automatic load_expected_stores();
        set_store(0, "and_reg_fwd", 16'hFFC2, 16'h0002);       // ~(11 & 13) & 11
        set_store(1, "add_reg_fwd", 16'hFFC4, 16'h000B);       // 7 + (7 - 3)
        set_store(2, "not_reg", 16'hFFC6, 16'hFFF6);
        set_store(3, "and_imm", 16'hFFC8, 16'h0009);
        set_store(4, "load_use", 16'hFFCA, LOAD_WORD + 16'd5);
        set_store(5, "branch_taken", 16'hFFCC, LOAD_WORD);
        set_store(6, "branch_not_taken", 16'hFFCE, 16'hFFFF);
        set_store(7, "fall_through_add", 16'hFFD0, 16'h0001);  // -1 + 2
    endtask

    assign exp_slot = (store_idx < NUM_STORES) ? store_idx : NUM_STORES - 1;

    always @(posedge clk) begin
        if (rst_n && write_b && resp_b) begin
            if (address_b == FLAG_ADDR) begin
                flag_seen <= 1'b1;
            end else begin
                store_idx <= store_idx + 1;
            end
        end
        if (rst_n && read_a && resp_a) begin
            fetch_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, final flag store never seen", cycles));
        end
    end

    store_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && resp_b && address_b != FLAG_ADDR |-> address_b == exp_addr[exp_slot])
        else report_mismatch({test_name[$sampled(exp_slot)], " address"},
                             exp_addr[$sampled(exp_slot)], $sampled(address_b));

    store_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && resp_b && address_b != FLAG_ADDR |-> wdata_b == exp_data[exp_slot])
        else report_mismatch({test_name[$sampled(exp_slot)], " data"},
                             exp_data[$sampled(exp_slot)], $sampled(wdata_b));

    no_extra_store: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && resp_b && address_b != FLAG_ADDR |-> store_idx < NUM_STORES)
        else fail_run("a store arrived after every expected store was already seen");

    flag_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && resp_b && address_b == FLAG_ADDR |-> store_idx == NUM_STORES)
        else fail_run("the final flag store arrived before all expected stores");

    flag_value: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && resp_b && address_b == FLAG_ADDR |-> wdata_b == LOAD_WORD)
        else report_mismatch("flag", LOAD_WORD, $sampled(wdata_b));

    // stores write the whole word
    store_mask_full: assert property (@(posedge clk) disable iff (!rst_n)
        write_b |-> wmask_b == 2'b11)
        else report_mismatch("store_mask", 16'h0003, {14'b0, $sampled(wmask_b)});

    // port A is an instruction read port only
    port_a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        !write_a && wmask_a == 2'b11 && wdata_a == '0)
        else fail_run("port A drove a write, a partial mask or write data");

    // the two stores behind the taken branch must never issue
    shadow_untouched: assert property (@(posedge clk) disable iff (!rst_n)
        write_b |-> address_b != SHADOW_ADDR)
        else fail_run("a squashed store wrote the shadow address");

    read_a_held: assert property (@(posedge clk) disable iff (!rst_n)
        read_a && !resp_a |=> read_a)
        else fail_run("read_a dropped before resp_a");

    read_b_held: assert property (@(posedge clk) disable iff (!rst_n)
        read_b && !resp_b |=> read_b)
        else fail_run("read_b dropped before resp_b");

    write_b_held: assert property (@(posedge clk) disable iff (!rst_n)
        write_b && !resp_b |=> write_b)
        else fail_run("write_b dropped before resp_b");

    port_b_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_b && write_b))
        else fail_run("read_b and write_b were high together");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !read_b && !write_b && !i_cpu_datapath.flush)
        else fail_run("port B or flush active during reset");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !read_b && !write_b && !i_cpu_datapath.flush)
        else fail_run("port B or flush active right after reset");

    first_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n)
        read_a && !fetch_seen |-> address_a == `LC3B_RESET_PC)
        else report_mismatch("reset_pc", `LC3B_RESET_PC, $sampled(address_a));

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        load_expected_stores();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait (flag_seen);
        repeat (4) @(posedge clk);  // a few spin cycles for any stray port B write
        if (store_idx == NUM_STORES) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d expected stores seen", store_idx, NUM_STORES));
        end
    end

endmodule

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model import lc3b_types::*; #(
    parameter lc3b_word LOAD_ADDR = 16'hFFC0,
    parameter lc3b_word LOAD_WORD = 16'h1234
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       read_a,
    input  lc3b_word   address_a,
    output logic       resp_a,
    output lc3b_word   rdata_a,
    input  logic       read_b,
    input  logic       write_b,
    input  logic [1:0] wmask_b,
    input  lc3b_word   address_b,
    input  lc3b_word   wdata_b,
    output logic       resp_b,
    output lc3b_word   rdata_b
);

    localparam int WORDS = 32768;   // full 64 KB space, no aliasing

    lc3b_word    mem [WORDS];
    logic [31:0] lfsr;
    logic        busy_a;
    logic        busy_b;
    logic [2:0]  wait_a;
    logic [2:0]  wait_b;
    logic [2:0]  lat;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32 + x^22 + x^2 + x + 1
    endfunction

    // two fresh bits per request give 1 to 4 cycles
    task automatic draw_latency(output logic [2:0] cycles);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        cycles = {1'b0, bits} + 3'd1;
    endtask

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
        mem[0]  = 16'h9E3F;     // not r7, r0
        mem[1]  = 16'h1227;     // add r1, r0, #7
        mem[2]  = 16'h147D;     // add r2, r1, #-3
        mem[3]  = 16'h1642;     // add r3, r1, r2
        mem[4]  = 16'h58ED;     // and r4, r3, #13
        mem[5]  = 16'h9B3F;     // not r5, r4
        mem[6]  = 16'h5D43;     // and r6, r5, r3
        mem[7]  = 16'h7C21;     // str r6, r0, #-31
        mem[8]  = 16'h7622;     // str r3, r0, #-30
        mem[9]  = 16'h7A23;     // str r5, r0, #-29
        mem[10] = 16'h7824;     // str r4, r0, #-28
        mem[11] = 16'h6220;     // ldr r1, r0, #-32
        mem[12] = 16'h1465;     // add r2, r1, #5
        mem[13] = 16'h7425;     // str r2, r0, #-27
        mem[14] = 16'h5620;     // and r3, r0, #0
        mem[15] = 16'h0402;     // brz +2
        mem[16] = 16'h7E38;     // str r7, r0, #-8   shadow
        mem[17] = 16'h7E38;     // str r7, r0, #-8   shadow
        mem[18] = 16'h7226;     // str r1, r0, #-26
        mem[19] = 16'h183F;     // add r4, r0, #-1
        mem[20] = 16'h0601;     // brzp +1
        mem[21] = 16'h7827;     // str r4, r0, #-25
        mem[22] = 16'h1B22;     // add r5, r4, #2
        mem[23] = 16'h7A28;     // str r5, r0, #-24
        mem[24] = 16'h723F;     // str r1, r0, #-1   flag
        mem[25] = 16'h0FFF;     // brnzp -1, spin here
        mem[LOAD_ADDR[15:1]] = LOAD_WORD;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr     = 32'h370;
            resp_a  <= 1'b0;
            rdata_a <= '0;
            busy_a  <= 1'b0;
            wait_a  <= '0;
            resp_b  <= 1'b0;
            rdata_b <= '0;
            busy_b  <= 1'b0;
            wait_b  <= '0;
        end else begin
            resp_a <= 1'b0;
            resp_b <= 1'b0;

            if (busy_a) begin
                if (wait_a == 3'd1) begin
                    resp_a  <= 1'b1;
                    rdata_a <= mem[address_a[15:1]];
                    busy_a  <= 1'b0;
                end else begin
                    wait_a <= wait_a - 3'd1;
                end
            end else if (read_a && !resp_a) begin     // new request, not the one just answered
                draw_latency(lat);
                busy_a <= 1'b1;
                wait_a <= lat;
            end

            if (busy_b) begin
                if (wait_b == 3'd1) begin
                    resp_b <= 1'b1;
                    busy_b <= 1'b0;
                    if (write_b) begin
                        if (wmask_b[0]) begin
                            mem[address_b[15:1]][7:0] <= wdata_b[7:0];
                        end
                        if (wmask_b[1]) begin
                            mem[address_b[15:1]][15:8] <= wdata_b[15:8];
                        end
                    end else begin
                        rdata_b <= mem[address_b[15:1]];
                    end
                end else begin
                    wait_b <= wait_b - 3'd1;
                end
            end else if ((read_b || write_b) && !resp_b) begin
                draw_latency(lat);
                busy_b <= 1'b1;
                wait_b <= lat;
            end
        end
    end

endmodule

// File: src/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,

    // port A, instruction reads
    input  logic       resp_a,
    input  lc3b_word   rdata_a,
    output logic       read_a,
    output logic       write_a,
    output logic [1:0] wmask_a,
    output lc3b_word   address_a,
    output lc3b_word   wdata_a,

    // port B, loads and stores
    input  logic       resp_b,
    input  lc3b_word   rdata_b,
    output logic       read_b,
    output logic       write_b,
    output logic [1:0] wmask_b,
    output lc3b_word   address_b,
    output lc3b_word   wdata_b
);

    if_id_t     if_out;
    if_id_t     if_id;
    id_ex_t     id_out;
    id_ex_t     id_ex;
    ex_mem_t    ex_out;
    ex_mem_t    ex_mem;
    mem_wb_t    mem_out;
    mem_wb_t    mem_wb;
    lc3b_word   pc_br;
    logic       flush;
    logic       stall_mem;
    logic       stall_fwd;
    logic       stall_fetch;
    logic       front_load;
    logic       if_id_flush;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;

    assign wmask_a = 2'b11;
    assign write_a = 1'b0;
    assign wdata_a = '0;

    assign front_load  = !stall_mem && !stall_fwd;
    assign if_id_flush = flush || (stall_fetch && front_load);  // nop while fetch waits

    fetch_stage i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall_mem || stall_fwd),
        .flush       (flush),
        .pc_br       (pc_br),
        .resp_a      (resp_a),
        .rdata_a     (rdata_a),
        .read_a      (read_a),
        .address_a   (address_a),
        .if_out      (if_out),
        .stall_fetch (stall_fetch)
    );

    stage_reg #(.T(if_id_t)) i_if_id_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (front_load),
        .flush (if_id_flush),
        .d     (if_out),
        .q     (if_id)
    );

    decode_stage i_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (if_id),
        .wb    (mem_wb),
        .out   (id_out)
    );

    stage_reg #(.T(id_ex_t)) i_id_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (front_load),
        .flush (flush),
        .d     (id_out),
        .q     (id_ex)
    );

    forwarding_unit i_forwarding (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .stall_fwd (stall_fwd)
    );

    execute_stage i_execute (
        .in      (id_ex),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .mem_fwd (ex_mem.alu),
        .wb_fwd  (mem_wb.dest_data),
        .bubble  (stall_fwd),
        .out     (ex_out)
    );

    stage_reg #(.T(ex_mem_t)) i_ex_mem_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (!stall_mem),
        .flush (flush),
        .d     (ex_out),
        .q     (ex_mem)
    );

    mem_stage i_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (ex_mem),
        .resp_b    (resp_b),
        .rdata_b   (rdata_b),
        .read_b    (read_b),
        .write_b   (write_b),
        .wmask_b   (wmask_b),
        .address_b (address_b),
        .wdata_b   (wdata_b),
        .out       (mem_out),
        .pc_br     (pc_br),
        .flush     (flush),
        .stall_mem (stall_mem)
    );

    // holds during a memory stall so WB forwarding stays valid for the held EX operand
    stage_reg #(.T(mem_wb_t)) i_mem_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (!stall_mem),
        .flush (1'b0),
        .d     (mem_out),
        .q     (mem_wb)
    );

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ex_mem_t    in,
    input  logic       resp_b,
    input  lc3b_word   rdata_b,
    output logic       read_b,
    output logic       write_b,
    output logic [1:0] wmask_b,
    output lc3b_word   address_b,
    output lc3b_word   wdata_b,
    output mem_wb_t    out,
    output lc3b_word   pc_br,
    output logic       flush,
    output logic       stall_mem
);

    logic [2:0] cc;
    logic [2:0] cc_next;
    logic       resp_q;
    logic       mem_op;

    assign mem_op    = in.ctrl.mem_read || in.ctrl.mem_write;
    assign read_b    = in.ctrl.mem_read && !resp_q;     // idle one cycle after each resp
    assign write_b   = in.ctrl.mem_write && !resp_q;
    assign wmask_b   = 2'b11;
    assign address_b = in.alu;
    assign wdata_b   = in.store_data;
    assign stall_mem = mem_op && !resp_b;

    assign pc_br = in.pc_br;
    assign flush = in.ctrl.is_br && |(in.ctrl.nzp & cc);

    always_comb begin
        out.ctrl      = in.ctrl;
        out.dest      = in.dest;
        out.dest_data = in.ctrl.mem_read ? rdata_b : in.alu;
    end

    always_comb begin
        cc_next[2] = out.dest_data[15];
        cc_next[1] = out.dest_data == '0;
        cc_next[0] = !out.dest_data[15] && out.dest_data != '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q <= 1'b0;
            cc     <= 3'b010;
        end else begin
            resp_q <= resp_b;
            if (in.ctrl.load_cc && !stall_mem) begin
                cc <= cc_next;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(read_b && write_b))
        else $error("mem_stage: read_b and write_b together");

    assert property (@(posedge clk) disable iff (!rst_n) !(flush && stall_mem))
        else $error("mem_stage: flush during memory stall");

endmodule

// File: src/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       stall_fwd
);

    logic hit_a;
    logic hit_b;

    function automatic logic [1:0] pick(logic used, lc3b_reg src, ex_mem_t m, mem_wb_t w);
        // load data is not ready in EX/MEM, it only comes back through MEM/WB
        if (used && m.ctrl.load_regfile && !m.ctrl.mem_read && m.dest == src) begin
            return fwd_mem;
        end
        if (used && w.ctrl.load_regfile && w.dest == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = pick(id_ex.ctrl.uses_sr1, id_ex.src1, ex_mem, mem_wb);
    assign fwd_b = pick(id_ex.ctrl.uses_sr2, id_ex.src2, ex_mem, mem_wb);

    assign hit_a     = id_ex.ctrl.uses_sr1 && ex_mem.dest == id_ex.src1;
    assign hit_b     = id_ex.ctrl.uses_sr2 && ex_mem.dest == id_ex.src2;
    assign stall_fwd = ex_mem.ctrl.mem_read && (hit_a || hit_b);

    // one bubble per load-use, longer only while the load waits on port B
    assert property (@(posedge clk) disable iff (!rst_n)
        stall_fwd |=> !stall_fwd || $stable(ex_mem))
        else $error("forwarding_unit: load-use stall repeated");

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import lc3b_types::*; (
    input  id_ex_t     in,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  lc3b_word   mem_fwd,
    input  lc3b_word   wb_fwd,
    input  logic       bubble,
    output ex_mem_t    out
);

    lc3b_word op_a;
    lc3b_word op_b;
    lc3b_word alu_b;
    lc3b_word alu_res;
    lc3b_word imm5;
    lc3b_word offset6;
    lc3b_word offset9;

    function automatic lc3b_word operand(logic [1:0] sel, lc3b_word rf, lc3b_word m,
                                         lc3b_word w);
        case (sel)
            fwd_mem: return m;
            fwd_wb:  return w;
            default: return rf;
        endcase
    endfunction

    assign imm5    = {{11{in.instruction[4]}}, in.instruction[4:0]};
    assign offset6 = {{10{in.instruction[5]}}, in.instruction[5:0]};
    assign offset9 = {{7{in.instruction[8]}}, in.instruction[8:0]};

    assign op_a  = operand(fwd_a, in.src1_data, mem_fwd, wb_fwd);
    assign op_b  = operand(fwd_b, in.src2_data, mem_fwd, wb_fwd);
    assign alu_b = in.ctrl.imm_sel ? imm5 : op_b;

    always_comb begin
        case (in.ctrl.aluop)
            alu_add: alu_res = op_a + alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_not: alu_res = ~op_a;
            default: alu_res = op_a;
        endcase
    end

    always_comb begin
        if (bubble) begin
            out.ctrl = '0;      // load-use hold, the instruction stays in ID/EX
        end else begin
            out.ctrl = in.ctrl;
        end
        out.dest  = in.dest;
        out.pc_br = in.pc + {offset9[14:0], 1'b0};
        if (in.ctrl.mem_read || in.ctrl.mem_write) begin
            out.alu = op_a + {offset6[14:0], 1'b0};     // word-scaled offset
        end else begin
            out.alu = alu_res;
        end
        out.store_data = op_b;
    end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module decode_stage import lc3b_types::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  if_id_t  in,
    input  mem_wb_t wb,
    output id_ex_t  out
);

    lc3b_word         regs [`LC3B_NUM_REGS];
    lc3b_word         inst;
    lc3b_control_word ctrl;
    lc3b_reg          src1;
    lc3b_reg          src2;
    lc3b_word         src1_data;
    lc3b_word         src2_data;

    assign inst = in.instruction;
    assign src1 = inst[8:6];
    assign src2 = (inst[15:12] == op_str) ? inst[11:9] : inst[2:0];    // str data on sr2

    always_comb begin
        ctrl = '0;
        case (inst[15:12])
            op_add: begin
                ctrl.opcode       = op_add;
                ctrl.aluop        = alu_add;
                ctrl.imm_sel      = inst[5];
                ctrl.uses_sr1     = 1'b1;
                ctrl.uses_sr2     = !inst[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_and: begin
                ctrl.opcode       = op_and;
                ctrl.aluop        = alu_and;
                ctrl.imm_sel      = inst[5];
                ctrl.uses_sr1     = 1'b1;
                ctrl.uses_sr2     = !inst[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_not: begin
                ctrl.opcode       = op_not;
                ctrl.aluop        = alu_not;
                ctrl.uses_sr1     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_ldr: begin
                ctrl.opcode       = op_ldr;
                ctrl.aluop        = alu_add;
                ctrl.uses_sr1     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            op_str: begin
                ctrl.opcode    = op_str;
                ctrl.aluop     = alu_add;
                ctrl.uses_sr1  = 1'b1;
                ctrl.uses_sr2  = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_br: begin
                ctrl.opcode = op_br;
                ctrl.aluop  = alu_pass;
                ctrl.is_br  = |inst[11:9];  // nzp 000 is a nop
                ctrl.nzp    = inst[11:9];
            end
            default: begin
                ctrl.aluop = alu_pass;      // unsupported opcodes retire as nops
            end
        endcase
    end

    // same-cycle writeback is visible to the read ports
    assign src1_data = (wb.ctrl.load_regfile && wb.dest == src1) ? wb.dest_data : regs[src1];
    assign src2_data = (wb.ctrl.load_regfile && wb.dest == src2) ? wb.dest_data : regs[src2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.ctrl.load_regfile) begin
            regs[wb.dest] <= wb.dest_data;
        end
    end

    always_comb begin
        out.ctrl        = ctrl;
        out.src1        = src1;
        out.src2        = src2;
        out.dest        = inst[11:9];
        out.pc          = in.pc;
        out.instruction = inst;
        out.src1_data   = src1_data;
        out.src2_data   = src2_data;
    end

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "lc3b_config.svh"

module fetch_stage import lc3b_types::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  lc3b_word pc_br,
    input  logic     resp_a,
    input  lc3b_word rdata_a,
    output logic     read_a,
    output lc3b_word address_a,
    output if_id_t   if_out,
    output logic     stall_fetch
);

    lc3b_word pc;           // address of the word being fetched
    logic     drop;         // read in flight belongs to a squashed path
    logic     held;
    lc3b_word held_inst;
    logic     avail;
    logic     accept;

    assign avail       = held || (read_a && resp_a && !drop);
    assign accept      = avail && !stall && !flush;
    assign stall_fetch = !avail;

    always_comb begin
        if_out.pc = pc + 16'd2;     // lc3b pc already points past the word
        if (avail) begin
            if_out.instruction = held ? held_inst : rdata_a;
        end else begin
            if_out.instruction = `LC3B_NOP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= `LC3B_RESET_PC;
            address_a <= `LC3B_RESET_PC;
            read_a    <= 1'b0;
            drop      <= 1'b0;
            held      <= 1'b0;
        end else begin
            if (read_a && resp_a) begin
                read_a <= 1'b0;
                drop   <= 1'b0;
            end else if (!read_a && !held && !flush) begin
                read_a    <= 1'b1;
                address_a <= pc;
            end

            if (flush) begin
                pc   <= pc_br;
                held <= 1'b0;
                if (read_a && !resp_a) begin
                    drop <= 1'b1;   // wait out the old read, discard its data
                end
            end else if (accept) begin
                pc   <= pc + 16'd2;
                held <= 1'b0;
            end else if (avail) begin
                held <= 1'b1;       // pipeline held, park the word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_a && resp_a) begin
            held_inst <= rdata_a;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        read_a && !resp_a |=> read_a && $stable(address_a))
        else $error("fetch_stage: port A request changed before resp_a");

endmodule

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic flush,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;    // zero payload decodes as a nop
        end else if (load) begin
            q <= d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        load && !flush |-> !$isunknown(d))
        else $error("stage_reg: unknown payload loaded");

endmodule

// File: src/lc3b_types.sv
`include "lc3b_config.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // operand source selects shared by forwarding and execute
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem  = 2'd1;
    localparam logic [1:0] fwd_wb   = 2'd2;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       imm_sel;       // imm5 replaces sr2
        logic       uses_sr1;
        logic       uses_sr2;
        logic       load_regfile;
        logic       load_cc;
        logic       mem_read;
        logic       mem_write;
        logic       is_br;
        logic [2:0] nzp;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word instruction;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg          src1;
        lc3b_reg          src2;
        lc3b_reg          dest;
        lc3b_word         pc;
        lc3b_word         instruction;
        lc3b_word         src1_data;
        lc3b_word         src2_data;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_word         pc_br;
        lc3b_word         alu;
        lc3b_word         store_data;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_word         dest_data;
    } mem_wb_t;

endpackage

// File: src/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// first fetch address
`define LC3B_RESET_PC 16'h0000

`define LC3B_NUM_REGS 8

// br with nzp = 000
`define LC3B_NOP 16'h0000

`endif
